// File: bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter
(
  input  logic              clock,
  input  logic              rst_n,
  input  bus_pkg::mem_req_t instr_req,
  input  bus_pkg::mem_req_t data_req,
  output bus_pkg::mem_rsp_t instr_rsp,
  output bus_pkg::mem_rsp_t data_rsp,
  output bus_pkg::mem_req_t target_req,
  input  bus_pkg::mem_rsp_t target_rsp
);

  bus_pkg::arb_state_t state;
  bus_pkg::arb_state_t grant;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant selection.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // When idle the choice is made in the same cycle, data before
  // instruction. Once held, the grant stays until the target answers.
  always_comb begin
    grant = state;
    if (state == bus_pkg::ARB_IDLE) begin
      if (data_req.valid) begin
        grant = bus_pkg::ARB_DATA;
      end else if (instr_req.valid) begin
        grant = bus_pkg::ARB_INSTR;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= bus_pkg::ARB_IDLE;
    end else if (target_rsp.ready) begin
      state <= bus_pkg::ARB_IDLE;
    end else begin
      state <= grant;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and response steering.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (grant)
      bus_pkg::ARB_DATA: begin
        target_req = data_req;
      end
      bus_pkg::ARB_INSTR: begin
        target_req = instr_req;
      end
      default: begin
        target_req = '0;
      end
    endcase
  end

  // The losing master sees neither ready nor data.
  always_comb begin
    instr_rsp = '0;
    data_rsp = '0;
    if (grant == bus_pkg::ARB_DATA) begin
      data_rsp = target_rsp;
    end else if (grant == bus_pkg::ARB_INSTR) begin
      instr_rsp = target_rsp;
    end
  end

endmodule

// File: bus_decoder.sv
`timescale 1ns/10ps

`include "bus_defines.svh"

module bus_decoder
(
  input  bus_pkg::mem_req_t req,
  output bus_pkg::mem_rsp_t rsp,
  output bus_pkg::mem_req_t tim_req,
  input  bus_pkg::mem_rsp_t tim_rsp,
  output bus_pkg::mem_req_t uart_req,
  input  bus_pkg::mem_rsp_t uart_rsp
);

  bus_pkg::target_t target;

  logic [`ADDR_WIDTH-1 : 0] base_addr;
  logic [`ADDR_WIDTH-1 : 0] offset;

  // Region select. An address outside both regions selects nothing.
  always_comb begin
    target = bus_pkg::TGT_NONE;
    base_addr = '0;
    if (req.addr >= `TIM_BASE_ADDR && req.addr < `TIM_TOP_ADDR) begin
      target = bus_pkg::TGT_TIM;
      base_addr = `TIM_BASE_ADDR;
    end else if (req.addr >= `UART_BASE_ADDR && req.addr < `UART_TOP_ADDR) begin
      target = bus_pkg::TGT_UART;
      base_addr = `UART_BASE_ADDR;
    end
  end

  assign offset = req.addr - base_addr;

  always_comb begin
    tim_req = req;
    tim_req.addr = offset;
    tim_req.valid = req.valid && (target == bus_pkg::TGT_TIM);

    uart_req = req;
    uart_req.addr = offset;
    uart_req.valid = req.valid && (target == bus_pkg::TGT_UART);
  end

  // Only the target holding this master's request can show ready here.
  always_comb begin
    if (tim_rsp.ready) begin
      rsp = tim_rsp;
    end else if (uart_rsp.ready) begin
      rsp = uart_rsp;
    end else begin
      rsp = '0;
    end
  end

endmodule

// File: bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN        64
`define ADDR_WIDTH  32
`define STRB_WIDTH  8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map. Top addresses are exclusive.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// The tim region spans TIM_DEPTH words of 8 bytes.
`define TIM_DEPTH       256
`define TIM_BASE_ADDR   32'h8000_0000
`define TIM_TOP_ADDR    32'h8000_0800

`define UART_BASE_ADDR  32'h1000_0000
`define UART_TOP_ADDR   32'h1000_1000

`endif

// File: bus_pkg.sv
`include "bus_defines.svh"

package bus_pkg;

  // A request with all strobes clear is a read.
  typedef struct packed {
    logic                         valid;
    logic                         instr;
    logic [`ADDR_WIDTH-1 : 0]     addr;
    logic [`XLEN-1 : 0]           wdata;
    logic [`STRB_WIDTH-1 : 0]     wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1 : 0]           rdata;
    logic                         ready;
  } mem_rsp_t;

  typedef enum logic [1 : 0] {
    TGT_NONE,
    TGT_TIM,
    TGT_UART
  } target_t;

  typedef enum logic [1 : 0] {
    ARB_IDLE,
    ARB_INSTR,
    ARB_DATA
  } arb_state_t;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module soc_bus_tb -o soc_bus_sim
output=$(./obj_dir/soc_bus_sim +verilator+error+limit+1000 || true)
echo "$output"
if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// File: soc_bus.sv
`timescale 1ns/10ps

module soc_bus
(
  input  logic              clock,
  input  logic              rst_n,
  input  bus_pkg::mem_req_t imem_req,
  input  bus_pkg::mem_req_t dmem_req,
  output bus_pkg::mem_rsp_t imem_rsp,
  output bus_pkg::mem_rsp_t dmem_rsp,
  output bus_pkg::mem_req_t uart_req,
  input  bus_pkg::mem_rsp_t uart_rsp
);

  bus_pkg::mem_req_t itim_req;
  bus_pkg::mem_rsp_t itim_rsp;
  bus_pkg::mem_req_t iuart_req;
  bus_pkg::mem_rsp_t iuart_rsp;

  bus_pkg::mem_req_t dtim_req;
  bus_pkg::mem_rsp_t dtim_rsp;
  bus_pkg::mem_req_t duart_req;
  bus_pkg::mem_rsp_t duart_rsp;

  bus_pkg::mem_req_t tim_req;
  bus_pkg::mem_rsp_t tim_rsp;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode, one per master.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  bus_decoder decoder_instr_comp
  (
    .req      (imem_req),
    .rsp      (imem_rsp),
    .tim_req  (itim_req),
    .tim_rsp  (itim_rsp),
    .uart_req (iuart_req),
    .uart_rsp (iuart_rsp)
  );

  bus_decoder decoder_data_comp
  (
    .req      (dmem_req),
    .rsp      (dmem_rsp),
    .tim_req  (dtim_req),
    .tim_rsp  (dtim_rsp),
    .uart_req (duart_req),
    .uart_rsp (duart_rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Targets, each behind its own arbiter.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  bus_arbiter arbiter_tim_comp
  (
    .clock      (clock),
    .rst_n      (rst_n),
    .instr_req  (itim_req),
    .data_req   (dtim_req),
    .instr_rsp  (itim_rsp),
    .data_rsp   (dtim_rsp),
    .target_req (tim_req),
    .target_rsp (tim_rsp)
  );

  tim tim_comp
  (
    .clock (clock),
    .rst_n (rst_n),
    .req   (tim_req),
    .rsp   (tim_rsp)
  );

  bus_arbiter arbiter_uart_comp
  (
    .clock      (clock),
    .rst_n      (rst_n),
    .instr_req  (iuart_req),
    .data_req   (duart_req),
    .instr_rsp  (iuart_rsp),
    .data_rsp   (duart_rsp),
    .target_req (uart_req),
    .target_rsp (uart_rsp)
  );

endmodule

// File: soc_bus_assertions.sv
`timescale 1ns/10ps

`include "bus_defines.svh"

module soc_bus_assertions
(
  input logic              clock,
  input logic              rst_n,
  input bus_pkg::mem_req_t imem_req,
  input bus_pkg::mem_req_t dmem_req,
  input bus_pkg::mem_rsp_t imem_rsp,
  input bus_pkg::mem_rsp_t dmem_rsp,
  input bus_pkg::mem_req_t uart_req,
  input bus_pkg::mem_rsp_t uart_rsp
);

  int   failures = 0;
  logic i_busy;
  logic d_busy;

  function automatic logic in_tim(input logic [`ADDR_WIDTH-1 : 0] addr);
    return addr >= `TIM_BASE_ADDR && addr < `TIM_TOP_ADDR;
  endfunction

  function automatic logic in_uart(input logic [`ADDR_WIDTH-1 : 0] addr);
    return addr >= `UART_BASE_ADDR && addr < `UART_TOP_ADDR;
  endfunction

  // A master is busy once its request has waited a cycle without ready.
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      i_busy <= 1'b0;
      d_busy <= 1'b0;
    end else begin
      i_busy <= imem_req.valid && !imem_rsp.ready;
      d_busy <= dmem_req.valid && !dmem_rsp.ready;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake rules.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_imem_ready: assert property (@(posedge clock) disable iff (!rst_n)
    imem_rsp.ready |-> imem_req.valid)
    else begin
      failures++;
      $error("imem ready without a pending request");
    end
  a_dmem_ready: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_rsp.ready |-> dmem_req.valid)
    else begin
      failures++;
      $error("dmem ready without a pending request");
    end
  a_uart_ready: assert property (@(posedge clock) disable iff (!rst_n)
    uart_rsp.ready |-> uart_req.valid)
    else begin
      failures++;
      $error("uart ready without a pending request");
    end

  a_imem_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (imem_req.valid && !imem_rsp.ready) |=> $stable(imem_req))
    else begin
      failures++;
      $error("imem request changed before ready");
    end
  a_dmem_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (dmem_req.valid && !dmem_rsp.ready) |=> $stable(dmem_req))
    else begin
      failures++;
      $error("dmem request changed before ready");
    end
  a_uart_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (uart_req.valid && !uart_rsp.ready) |=> $stable(uart_req))
    else begin
      failures++;
      $error("uart request changed before ready");
    end

  // Both masters can finish together only when one of them is at the UART.
  a_both_ready: assert property (@(posedge clock) disable iff (!rst_n)
    (imem_rsp.ready && dmem_rsp.ready) |-> (in_uart(imem_req.addr) || in_uart(dmem_req.addr)))
    else begin
      failures++;
      $error("both masters ready from the tim");
    end

  a_tim_dmem: assert property (@(posedge clock) disable iff (!rst_n)
    (dmem_req.valid && in_tim(dmem_req.addr) && !d_busy &&
     !(imem_req.valid && in_tim(imem_req.addr))) |=> dmem_rsp.ready)
    else begin
      failures++;
      $error("dmem tim access not ready after one cycle");
    end
  a_tim_imem: assert property (@(posedge clock) disable iff (!rst_n)
    (imem_req.valid && in_tim(imem_req.addr) && !i_busy &&
     !(dmem_req.valid && in_tim(dmem_req.addr))) |=> imem_rsp.ready)
    else begin
      failures++;
      $error("imem tim access not ready after one cycle");
    end

endmodule

bind soc_bus soc_bus_assertions i_soc_bus_assertions
(
  .clock    (clock),
  .rst_n    (rst_n),
  .imem_req (imem_req),
  .dmem_req (dmem_req),
  .imem_rsp (imem_rsp),
  .dmem_rsp (dmem_rsp),
  .uart_req (uart_req),
  .uart_rsp (uart_rsp)
);

// File: soc_bus_tb.sv
`timescale 1ns/10ps

`include "bus_defines.svh"

module soc_bus_tb;

  localparam int TIMEOUT = 50;
  localparam logic [63:0] UART_CONST = 64'h5a5a_0000_0000_0000;
  localparam logic [31:0] TB = `TIM_BASE_ADDR;
  localparam logic [31:0] UB = `UART_BASE_ADDR;

  logic              clock;
  logic              rst_n;
  bus_pkg::mem_req_t imem_req;
  bus_pkg::mem_req_t dmem_req;
  bus_pkg::mem_rsp_t imem_rsp;
  bus_pkg::mem_rsp_t dmem_rsp;
  bus_pkg::mem_req_t uart_req;
  bus_pkg::mem_rsp_t uart_rsp;

  logic [7:0]  model [0 : `TIM_DEPTH*8-1];
  logic [31:0] exp_uart_addr;
  logic [63:0] exp_uart_wdata;
  logic [7:0]  exp_uart_wstrb;
  logic        exp_uart_instr;
  integer      seed = 32'h75259ea6;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          last_errors = 0;
  logic [63:0] rd_i;
  logic [63:0] rd_d;
  logic [63:0] rand_wdata;
  int          cyc_i;
  int          cyc_d;
  int          delay;

  soc_bus i_soc_bus (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int total;
    total = errors + i_soc_bus.i_soc_bus_assertions.failures;
    if (total == last_errors) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, total - last_errors);
    end
    last_errors = total;
  endtask

  function automatic logic [63:0] model_read(input logic [31:0] addr);
    logic [63:0] word;
    for (int i = 0; i < 8; i++) begin
      word[8*i +: 8] = model[{(addr - TB) & 32'hfffffff8} + i];
    end
    return word;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] wstrb);
    for (int i = 0; i < 8; i++) begin
      if (wstrb[i]) begin
        model[((addr - TB) & 32'hfffffff8) + i] = wdata[8*i +: 8];
      end
    end
  endtask

  // Issues one request on a master port and waits for its ready.
  task automatic access(input logic is_data, input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] wstrb, output logic [63:0] rdata, output int cycles);
    bus_pkg::mem_req_t req;
    bus_pkg::mem_rsp_t rsp;
    logic              done;
    req = '{valid: 1'b1, instr: !is_data, addr: addr, wdata: wdata, wstrb: wstrb};
    done = 1'b0;
    rdata = '0;
    cycles = 0;
    @(negedge clock);
    if (is_data) dmem_req = req;
    else imem_req = req;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clock);
      cycles++;
      rsp = is_data ? dmem_rsp : imem_rsp;
      if (rsp.ready) begin
        rdata = rsp.rdata;
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("Timeout: the %s port never answered a request to %h",
               is_data ? "dmem" : "imem", addr);
      errors++;
    end
    @(negedge clock);
    if (is_data) dmem_req = '0;
    else imem_req = '0;
  endtask

  // UART responder with a random delay of 1 to 6 cycles.
  initial begin
    uart_rsp = '0;
    forever begin
      @(posedge clock);
      if (rst_n && uart_req.valid) begin
        check_value("uart_req.addr", {32'h0, exp_uart_addr}, {32'h0, uart_req.addr});
        check_value("uart_req.wdata", exp_uart_wdata, uart_req.wdata);
        check_value("uart_req.wstrb", {56'h0, exp_uart_wstrb}, {56'h0, uart_req.wstrb});
        check_value("uart_req.instr", {63'h0, exp_uart_instr}, {63'h0, uart_req.instr});
        delay = 1 + int'({$random(seed)} % 6);
        repeat (delay - 1) @(posedge clock);
        @(negedge clock);
        uart_rsp.rdata = {32'h0, uart_req.addr} + UART_CONST;
        uart_rsp.ready = 1'b1;
        @(negedge clock);
        uart_rsp = '0;
      end
    end
  end

  task automatic uart_access(input logic is_data, input logic [31:0] off, input logic [63:0] wdata,
                             input logic [7:0] wstrb);
    exp_uart_addr = off;
    exp_uart_wdata = wdata;
    exp_uart_wstrb = wstrb;
    exp_uart_instr = !is_data;
    access(is_data, UB + off, wdata, wstrb, rd_d, cyc_d);
    if (wstrb == 8'h0) check_value("uart rdata", {32'h0, off} + UART_CONST, rd_d);
    // The request reaches the UART in its first cycle, so ready follows the delay by one.
    check_value(is_data ? "dmem_rsp.ready cycles" : "imem_rsp.ready cycles", 64'(delay + 1),
                64'(cyc_d));
  endtask

  initial begin
    rst_n = 1'b0;
    imem_req = '0;
    dmem_req = '0;
    exp_uart_addr = '0;
    exp_uart_wdata = '0;
    exp_uart_wstrb = '0;
    exp_uart_instr = 1'b0;
    for (int c = 0; c < 5; c++) begin
      @(negedge clock);
      if (c == 4) rst_n = 1'b1;
      if (c > 0) begin
        check_value("imem_rsp.ready", 64'h0, {63'h0, imem_rsp.ready});
        check_value("dmem_rsp.ready", 64'h0, {63'h0, dmem_rsp.ready});
        check_value("uart_req.valid", 64'h0, {63'h0, uart_req.valid});
      end
    end
    @(negedge clock);
    check_value("imem_rsp.ready", 64'h0, {63'h0, imem_rsp.ready});
    check_value("dmem_rsp.ready", 64'h0, {63'h0, dmem_rsp.ready});
    check_value("uart_req.valid", 64'h0, {63'h0, uart_req.valid});
    end_test("reset");

    access(1'b1, TB + 32'h10, 64'h1122_3344_5566_7788, 8'hff, rd_d, cyc_d);
    model_write(TB + 32'h10, 64'h1122_3344_5566_7788, 8'hff);
    access(1'b1, TB + 32'h10, 64'haabb_ccdd_eeff_0011, 8'h0f, rd_d, cyc_d);
    model_write(TB + 32'h10, 64'haabb_ccdd_eeff_0011, 8'h0f);
    access(1'b1, TB + 32'h10, 64'h9988_7766_5544_3322, 8'ha0, rd_d, cyc_d);
    model_write(TB + 32'h10, 64'h9988_7766_5544_3322, 8'ha0);
    access(1'b1, TB + 32'h7f8, 64'hdead_beef_0bad_f00d, 8'hff, rd_d, cyc_d);
    model_write(TB + 32'h7f8, 64'hdead_beef_0bad_f00d, 8'hff);
    rand_wdata = {$random(seed), $random(seed)};
    access(1'b1, TB + 32'h7f8, rand_wdata, 8'h3c, rd_d, cyc_d);
    model_write(TB + 32'h7f8, rand_wdata, 8'h3c);
    access(1'b1, TB + 32'h10, 64'h0, 8'h00, rd_d, cyc_d);
    check_value("dmem_rsp.rdata", model_read(TB + 32'h10), rd_d);
    access(1'b1, TB + 32'h7f8, 64'h0, 8'h00, rd_d, cyc_d);
    check_value("dmem_rsp.rdata", model_read(TB + 32'h7f8), rd_d);
    end_test("byte strobes");

    access(1'b0, TB + 32'h10, 64'h0, 8'h00, rd_i, cyc_i);
    check_value("imem_rsp.rdata", model_read(TB + 32'h10), rd_i);
    end_test("shared memory");

    uart_access(1'b1, 32'h20, 64'h0123_4567_89ab_cdef, 8'h3c);
    uart_access(1'b1, 32'h8, 64'h0, 8'h00);
    uart_access(1'b0, 32'h40, 64'h0, 8'h00);
    end_test("uart port");

    fork
      access(1'b1, TB + 32'h7f8, 64'h0, 8'h00, rd_d, cyc_d);
      access(1'b0, TB + 32'h10, 64'h0, 8'h00, rd_i, cyc_i);
    join
    check_value("dmem_rsp.rdata", model_read(TB + 32'h7f8), rd_d);
    check_value("imem_rsp.rdata", model_read(TB + 32'h10), rd_i);
    if (cyc_d >= cyc_i) begin
      $display("Contention: the data port was not served before the instruction port");
      errors++;
    end
    end_test("contention");

    exp_uart_addr = 32'h18;
    exp_uart_wdata = 64'h0;
    exp_uart_wstrb = 8'h0;
    exp_uart_instr = 1'b0;
    fork
      access(1'b1, UB + 32'h18, 64'h0, 8'h00, rd_d, cyc_d);
      access(1'b0, TB + 32'h7f8, 64'h0, 8'h00, rd_i, cyc_i);
    join
    check_value("dmem_rsp.rdata", 64'h18 + UART_CONST, rd_d);
    check_value("imem_rsp.rdata", model_read(TB + 32'h7f8), rd_i);
    if (cyc_i > cyc_d) begin
      $display("Two in flight: the tim access did not finish within the UART delay");
      errors++;
    end
    end_test("two in flight");

    repeat (2) @(negedge clock);
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d", passed, failed,
             i_soc_bus.i_soc_bus_assertions.failures);
    if (errors == 0 && i_soc_bus.i_soc_bus_assertions.failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
bus_pkg.sv
bus_decoder.sv
bus_arbiter.sv
tim.sv
soc_bus.sv
soc_bus_assertions.sv
soc_bus_tb.sv

// File: tim.sv
`timescale 1ns/10ps

`include "bus_defines.svh"

module tim
(
  input  logic              clock,
  input  logic              rst_n,
  input  bus_pkg::mem_req_t req,
  output bus_pkg::mem_rsp_t rsp
);

  localparam int OFFSET_WIDTH = $clog2(`STRB_WIDTH);
  localparam int INDEX_WIDTH = $clog2(`TIM_DEPTH);

  logic [`XLEN-1 : 0] mem [0 : `TIM_DEPTH-1];

  logic [INDEX_WIDTH-1 : 0] index;
  logic [`XLEN-1 : 0]       rdata;
  logic                     ready;
  logic                     access;

  // Word index, with the byte offset dropped.
  assign index = req.addr[INDEX_WIDTH+OFFSET_WIDTH-1 : OFFSET_WIDTH];

  // A held request is served once. The cycle after ready is always
  // free, so a new request can follow at once.
  assign access = req.valid && !ready;

  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < `STRB_WIDTH; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
      rdata <= mem[index];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  assign rsp.rdata = rdata;
  assign rsp.ready = ready;

endmodule
